// ==== rtl/gpio_pkg.sv ====
// shared constants for the apb gpio block
// pin count is fixed at 16, so other widths need rework in every module
// apb data is 32 bits, only the low 16 carry register content
// register map is word aligned, byte offsets below
// unlisted offsets read zero and ignore writes

package gpio_pkg;

   // --------------------
   // widths
   // --------------------
   localparam int GPIO_WIDTH  = 16;   // pins handled by one instance
   localparam int APB_ADDR_W  = 6;    // byte address, 64 byte window
   localparam int APB_DATA_W  = 32;   // apb bus width

   // input synchronizer depth, metastability guard
   localparam int SYNC_STAGES = 2;

   // --------------------
   // register offsets
   // --------------------
   // direction, 1 = output
   localparam logic [APB_ADDR_W-1:0] ADDR_DIR      = 6'h00;
   // drive values for output pins
   localparam logic [APB_ADDR_W-1:0] ADDR_OUT      = 6'h04;
   // synchronized pin levels, read only
   localparam logic [APB_ADDR_W-1:0] ADDR_IN       = 6'h08;
   // per pin interrupt enable
   localparam logic [APB_ADDR_W-1:0] ADDR_INT_EN   = 6'h0C;
   // edge select, 1 = rising, 0 = falling
   localparam logic [APB_ADDR_W-1:0] ADDR_INT_POL  = 6'h10;
   // sticky status, write 1 to clear
   localparam logic [APB_ADDR_W-1:0] ADDR_INT_STAT = 6'h14;

   // --------------------
   // misc
   // --------------------
   // zero fill above the pin field in read data
   localparam int RDATA_PAD = APB_DATA_W - GPIO_WIDTH;

endpackage : gpio_pkg

// ==== rtl/gpio_cfg_if.sv ====
// config and status bundle between register block and pin logic
// no clock inside, both sides sample on their own pclk
// int_clr is a single cycle pulse, level use is wrong

`timescale 1ns/1ps

interface gpio_cfg_if;
   import gpio_pkg::*;

   // from the register block
   logic [GPIO_WIDTH-1:0] dir;        // 1 = pin drives
   logic [GPIO_WIDTH-1:0] out_data;   // value on driven pins
   logic [GPIO_WIDTH-1:0] int_en;     // edge irq enable
   logic [GPIO_WIDTH-1:0] int_pol;    // 1 rising, 0 falling
   logic [GPIO_WIDTH-1:0] int_clr;    // w1c bits, one cycle

   // from the pin logic
   logic [GPIO_WIDTH-1:0] pin_val;    // synced input levels
   logic [GPIO_WIDTH-1:0] int_stat;   // sticky edge status

   // register side
   modport regs (
      output dir, out_data, int_en, int_pol, int_clr,
      input  pin_val, int_stat
   );

   // pin side
   modport pins (
      input  dir, out_data, int_en, int_pol, int_clr,
      output pin_val, int_stat
   );

endinterface : gpio_cfg_if

// ==== rtl/gpio_apb_regs.sv ====
// apb register file for the gpio block
// strobes come fully decoded from the top, one cycle each
// writes land on the edge ending the access phase
// rdata loads on the edge ending the setup phase and holds until the next read
// upper 16 bits of rdata always zero
// int_clr is combinational from the write strobe so the clear hits the write edge

`timescale 1ns/1ps

module gpio_apb_regs (
   input  logic                          pclk,
   input  logic                          reset,
   input  logic                          wr_stb,   // psel & penable & pwrite
   input  logic                          rd_stb,   // psel & ~penable & ~pwrite
   input  logic [gpio_pkg::APB_ADDR_W-1:0] addr,
   input  logic [gpio_pkg::GPIO_WIDTH-1:0] wdata,
   output logic [gpio_pkg::APB_DATA_W-1:0] rdata,
   gpio_cfg_if.regs                      cfg
);
   import gpio_pkg::*;

   // --------------------
   // storage
   // --------------------
   logic [GPIO_WIDTH-1:0] dir_q;       // pin direction
   logic [GPIO_WIDTH-1:0] out_q;       // output values
   logic [GPIO_WIDTH-1:0] int_en_q;    // irq enables
   logic [GPIO_WIDTH-1:0] int_pol_q;   // edge polarity
   logic [GPIO_WIDTH-1:0] rd_mux;      // selected read word

   // write decode, one register per offset
   always_ff @(posedge pclk)
   begin
      if (reset)
      begin
         dir_q     <= '0;
         out_q     <= '0;
         int_en_q  <= '0;
         int_pol_q <= '0;
      end
      else if (wr_stb)
      begin
         case (addr)
            ADDR_DIR:     dir_q     <= wdata;
            ADDR_OUT:     out_q     <= wdata;
            ADDR_INT_EN:  int_en_q  <= wdata;
            ADDR_INT_POL: int_pol_q <= wdata;
            default:      ;   // in, stat and holes, no storage here
         endcase
      end
   end

   // w1c pulse toward the status bits in pin logic
   always_comb
   begin
      if (wr_stb && (addr == ADDR_INT_STAT))
         cfg.int_clr = wdata;
      else
         cfg.int_clr = '0;
   end

   assign cfg.dir      = dir_q;
   assign cfg.out_data = out_q;
   assign cfg.int_en   = int_en_q;
   assign cfg.int_pol  = int_pol_q;

   // --------------------
   // read path
   // --------------------
   always_comb
   begin
      case (addr)
         ADDR_DIR:      rd_mux = dir_q;
         ADDR_OUT:      rd_mux = out_q;
         ADDR_IN:       rd_mux = cfg.pin_val;    // synced levels
         ADDR_INT_EN:   rd_mux = int_en_q;
         ADDR_INT_POL:  rd_mux = int_pol_q;
         ADDR_INT_STAT: rd_mux = cfg.int_stat;
         default:       rd_mux = '0;             // unmapped reads zero
      endcase
   end

   // registered read data, valid through the access phase
   always_ff @(posedge pclk)
   begin
      if (reset)
         rdata <= '0;
      else if (rd_stb)
         rdata <= {{RDATA_PAD{1'b0}}, rd_mux};   // pad upper half
   end

   // --------------------
   // checks
   // --------------------
   // setup and access phases never overlap on the bus
   a_stb_excl : assert property (@(posedge pclk) disable iff (reset)
      !(wr_stb && rd_stb))
      else $error("read and write strobe high in the same cycle");

   // clear only with a write, and never two cycles running
   a_clr_pulse : assert property (@(posedge pclk) disable iff (reset)
      (cfg.int_clr != '0) |-> wr_stb ##1 (cfg.int_clr == '0))
      else $error("int_clr outside a single write cycle");

endmodule : gpio_apb_regs

// ==== rtl/gpio_pin_ctrl.sv ====
// pin side of the gpio block
// inputs pass a 2 flop synchronizer, pin_val lags the pin by two edges
// one history flop gives edge detect, status sets on the third edge
// edge interrupts only, no level mode and no debounce
// set beats a same cycle w1c clear
// tri_state_enable overrides dir and forces the pin to input

`timescale 1ns/1ps

module gpio_pin_ctrl (
   input  logic                          pclk,
   input  logic                          reset,
   input  logic [gpio_pkg::GPIO_WIDTH-1:0] pin_in,
   input  logic [gpio_pkg::GPIO_WIDTH-1:0] tri_state_enable,
   output logic [gpio_pkg::GPIO_WIDTH-1:0] pin_out,
   output logic [gpio_pkg::GPIO_WIDTH-1:0] pin_oe_n,
   output logic                          irq,
   gpio_cfg_if.pins                      cfg
);
   import gpio_pkg::*;

   logic [GPIO_WIDTH-1:0] sync_q [SYNC_STAGES];   // sync chain, [0] meets the pin
   logic [GPIO_WIDTH-1:0] prev_q;                 // last synced value
   logic [GPIO_WIDTH-1:0] rise;
   logic [GPIO_WIDTH-1:0] fall;
   logic [GPIO_WIDTH-1:0] edge_hit;               // qualified edges this cycle
   logic [GPIO_WIDTH-1:0] stat_q;

   // --------------------
   // synchronizer
   // --------------------
   always_ff @(posedge pclk)
   begin
      if (reset)
      begin
         for (int i = 0; i < SYNC_STAGES; i++)
            sync_q[i] <= '0;
         prev_q <= '0;
      end
      else
      begin
         sync_q[0] <= pin_in;
         for (int i = 1; i < SYNC_STAGES; i++)
            sync_q[i] <= sync_q[i-1];
         prev_q <= sync_q[SYNC_STAGES-1];   // history for edge detect
      end
   end

   assign cfg.pin_val = sync_q[SYNC_STAGES-1];

   // --------------------
   // edge interrupts
   // --------------------
   assign rise     = cfg.pin_val & ~prev_q;
   assign fall     = ~cfg.pin_val & prev_q;
   // pol picks the direction per pin, then enable
   assign edge_hit = cfg.int_en & ((cfg.int_pol & rise) | (~cfg.int_pol & fall));

   always_ff @(posedge pclk)
   begin
      if (reset)
         stat_q <= '0;
      else
         stat_q <= (stat_q & ~cfg.int_clr) | edge_hit;   // set wins over clear
   end

   assign cfg.int_stat = stat_q;
   assign irq          = |stat_q;

   // outputs, straight from config
   assign pin_out  = cfg.out_data;
   assign pin_oe_n = ~(cfg.dir & ~tri_state_enable);   // low = drive

   // status bits only rise on enabled pins
   a_stat_en : assert property (@(posedge pclk) disable iff (reset)
      (stat_q & ~$past(stat_q) & ~$past(cfg.int_en)) == '0)
      else $error("int_stat bit set without int_en");

endmodule : gpio_pin_ctrl

// ==== rtl/gpio_apb_top.sv ====
// apb gpio top level, 16 pins
// apb2 style slave, every transfer is two cycles, no pready or pslverr
// read data registered in setup, valid during access
// gpio_int is the OR of all status bits, combinational
// no scan ports, test insertion adds them later

`timescale 1ns/1ps

module gpio_apb_top (
   input  logic                          pclk,
   input  logic                          reset,
   input  logic                          psel,
   input  logic                          penable,
   input  logic                          pwrite,
   input  logic [gpio_pkg::APB_ADDR_W-1:0] paddr,
   input  logic [gpio_pkg::APB_DATA_W-1:0] pwdata,
   input  logic [gpio_pkg::GPIO_WIDTH-1:0] gpio_pin_in,
   input  logic [gpio_pkg::GPIO_WIDTH-1:0] tri_state_enable,   // 1 forces input
   output logic [gpio_pkg::APB_DATA_W-1:0] prdata,
   output logic [gpio_pkg::GPIO_WIDTH-1:0] gpio_pin_out,
   output logic [gpio_pkg::GPIO_WIDTH-1:0] n_gpio_pin_oe,
   output logic                          gpio_int
);
   import gpio_pkg::*;

   // --------------------
   // apb strobes
   // --------------------
   logic write;   // access phase of a write
   logic read;    // setup phase of a read

   assign write = psel & penable & pwrite;
   assign read  = psel & ~penable & ~pwrite;

   gpio_cfg_if cfg_bus ();

   gpio_apb_regs u_regs (
      .pclk   (pclk),
      .reset  (reset),
      .wr_stb (write),
      .rd_stb (read),
      .addr   (paddr),
      .wdata  (pwdata[GPIO_WIDTH-1:0]),   // upper bits dropped
      .rdata  (prdata),
      .cfg    (cfg_bus.regs)
   );

   gpio_pin_ctrl u_pins (
      .pclk             (pclk),
      .reset            (reset),
      .pin_in           (gpio_pin_in),
      .tri_state_enable (tri_state_enable),
      .pin_out          (gpio_pin_out),
      .pin_oe_n         (n_gpio_pin_oe),
      .irq              (gpio_int),
      .cfg              (cfg_bus.pins)
   );

endmodule : gpio_apb_top

// ==== test/tb_gpio_apb.sv ====
// table driven testbench for the apb gpio top level
// expected values come from a small register model built with the table
// pin changes wait four idle cycles to cover the three edge input latency
// inputs change on the falling edge and outputs are sampled there
// first mismatch ends the run

`timescale 1ns/1ps

module tb_gpio_apb;
   import gpio_pkg::*;

   localparam int OP_WR  = 0;   // apb write
   localparam int OP_RD  = 1;   // apb read and compare
   localparam int OP_PIN = 2;   // drive gpio_pin_in
   localparam int OP_TRI = 3;   // drive tri_state_enable
   localparam int OP_CHK = 4;   // compare pin side outputs
   localparam int RESET_CYCLES = 16;

   logic                  pclk = 1'b0;
   logic                  reset;
   logic                  psel, penable, pwrite;
   logic [APB_ADDR_W-1:0] paddr;
   logic [APB_DATA_W-1:0] pwdata, prdata;
   logic [GPIO_WIDTH-1:0] gpio_pin_in, tri_state_enable;
   logic [GPIO_WIDTH-1:0] gpio_pin_out, n_gpio_pin_oe;
   logic                  gpio_int;

   // --------------------
   // stimulus table and model
   // --------------------
   int                    op_q[$];
   logic [APB_ADDR_W-1:0] addr_q[$];
   logic [31:0]           data_q[$];
   logic [31:0]           exp_q[$];    // pin check holds {int, n_oe}
   string                 name_q[$];
   logic [GPIO_WIDTH-1:0] m_dir, m_out, m_en, m_pol, m_stat, m_pin, m_tri;
   logic [31:0]           seed = 32'h1447;
   logic [31:0]           rd;
   int                    cycles = 0;
   int                    limit = 0;

   gpio_apb_top dut (.*);

   always #20 pclk = ~pclk;   // 40 ns period

   // run length guard
   always @(posedge pclk)
   begin
      cycles++;
      if (limit > 0 && cycles > limit)
      begin
         $display("timeout: table did not finish within %0d cycles", limit);
         $display("STATUS: FAIL");
         $fatal(1, "cycle limit reached");
      end
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic logic [31:0] expected_read(input logic [APB_ADDR_W-1:0] a);
      case (a)
         ADDR_DIR:      return {16'h0, m_dir};
         ADDR_OUT:      return {16'h0, m_out};
         ADDR_IN:       return {16'h0, m_pin};
         ADDR_INT_EN:   return {16'h0, m_en};
         ADDR_INT_POL:  return {16'h0, m_pol};
         ADDR_INT_STAT: return {16'h0, m_stat};
         default:       return 32'h0;   // holes
      endcase
   endfunction

   task automatic enqueue(input int op, input logic [APB_ADDR_W-1:0] a,
                          input logic [31:0] d, input logic [31:0] e, input string n);
      op_q.push_back(op);
      addr_q.push_back(a);
      data_q.push_back(d);
      exp_q.push_back(e);
      name_q.push_back(n);
   endtask

   task automatic write_entry(input logic [APB_ADDR_W-1:0] a, input logic [31:0] d);
      enqueue(OP_WR, a, d, 32'h0, "write");
      case (a)
         ADDR_DIR:      m_dir = d[15:0];
         ADDR_OUT:      m_out = d[15:0];
         ADDR_INT_EN:   m_en  = d[15:0];
         ADDR_INT_POL:  m_pol = d[15:0];
         ADDR_INT_STAT: m_stat = m_stat & ~d[15:0];   // w1c
         default:       ;
      endcase
   endtask

   task automatic read_entry(input logic [APB_ADDR_W-1:0] a, input string n);
      enqueue(OP_RD, a, 32'h0, expected_read(a), n);
   endtask

   // edges against the previous pattern feed the status model
   task automatic pin_entry(input logic [GPIO_WIDTH-1:0] v);
      for (int i = 0; i < GPIO_WIDTH; i++)
      begin
         // enabled pin that moved to the level its polarity names
         if (m_en[i] && (v[i] != m_pin[i]) && (v[i] == m_pol[i]))
            m_stat[i] = 1'b1;
      end
      m_pin = v;
      enqueue(OP_PIN, '0, {16'h0, v}, 32'h0, "pins");
   endtask

   task automatic tri_entry(input logic [GPIO_WIDTH-1:0] v);
      m_tri = v;
      enqueue(OP_TRI, '0, {16'h0, v}, 32'h0, "tri");
   endtask

   task automatic output_entry(input string n);
      enqueue(OP_CHK, '0, {16'h0, m_out}, {15'h0, |m_stat, ~m_dir | m_tri}, n);
   endtask

   // --------------------
   // bus and check tasks
   // --------------------
   task automatic check_val(input string n, input logic [31:0] e, input logic [31:0] a);
      if (e !== a)
      begin
         $display("[FAIL] %s expected %h actual %h", n, e, a);
         $display("STATUS: FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic apb_write(input logic [APB_ADDR_W-1:0] a, input logic [31:0] d);
      @(negedge pclk);
      psel    = 1'b1;   // setup
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = a;
      pwdata  = d;
      @(negedge pclk);
      penable = 1'b1;   // access
      @(negedge pclk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_read(input logic [APB_ADDR_W-1:0] a, output logic [31:0] d);
      @(negedge pclk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = a;
      @(negedge pclk);
      penable = 1'b1;
      d = prdata;   // loaded at end of setup
      @(negedge pclk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   initial
   begin
      reset            = 1'b1;
      psel             = 1'b0;
      penable          = 1'b0;
      pwrite           = 1'b0;
      paddr            = '0;
      pwdata           = '0;
      gpio_pin_in      = '0;
      tri_state_enable = '0;
      {m_dir, m_out, m_en, m_pol, m_stat, m_pin, m_tri} = '0;

      // reset state
      read_entry(ADDR_DIR, "rst_dir");
      read_entry(ADDR_OUT, "rst_out");
      read_entry(ADDR_IN, "rst_in");
      read_entry(ADDR_INT_EN, "rst_en");
      read_entry(ADDR_INT_POL, "rst_pol");
      read_entry(ADDR_INT_STAT, "rst_stat");
      read_entry(6'h18, "rst_hole");
      output_entry("rst_pins");
      // random word readback drops the upper half
      seed = lcg_next(seed);
      write_entry(ADDR_DIR, seed);
      read_entry(ADDR_DIR, "rb_dir");
      seed = lcg_next(seed);
      write_entry(ADDR_OUT, seed);
      read_entry(ADDR_OUT, "rb_out");
      seed = lcg_next(seed);
      write_entry(ADDR_INT_EN, seed);
      read_entry(ADDR_INT_EN, "rb_en");
      seed = lcg_next(seed);
      write_entry(ADDR_INT_POL, seed);
      read_entry(ADDR_INT_POL, "rb_pol");
      seed = lcg_next(seed);
      write_entry(6'h1C, seed);
      read_entry(6'h1C, "hole_rd");
      read_entry(ADDR_DIR, "hole_dir");
      read_entry(ADDR_OUT, "hole_out");
      read_entry(ADDR_INT_EN, "hole_en");
      read_entry(ADDR_INT_POL, "hole_pol");
      // pin outputs
      output_entry("out_rand");
      tri_entry(16'hF0F0);
      output_entry("out_tri");
      write_entry(ADDR_DIR, 32'h0000_A5A5);
      write_entry(ADDR_OUT, 32'hFFFF_3C3C);
      output_entry("out_fixed");
      tri_entry(16'h0FF0);
      output_entry("tri_only");
      tri_entry(16'h0000);
      output_entry("tri_clear");
      // input sampling
      seed = lcg_next(seed);
      pin_entry(seed[15:0]);
      read_entry(ADDR_IN, "in_rand");
      pin_entry(16'h5A5A);
      read_entry(ADDR_IN, "in_fixed");
      // edge interrupts from a clean status
      write_entry(ADDR_INT_EN, 32'h0);
      write_entry(ADDR_INT_STAT, 32'hFFFF);
      pin_entry(16'h0000);
      read_entry(ADDR_INT_STAT, "irq_idle");
      output_entry("irq_idle_pins");
      write_entry(ADDR_INT_EN, 32'h00FF);
      write_entry(ADDR_INT_POL, 32'h0F0F);
      pin_entry(16'hFFFF);
      read_entry(ADDR_INT_STAT, "irq_rise");
      output_entry("irq_rise_pins");
      pin_entry(16'h00F0);
      read_entry(ADDR_INT_STAT, "irq_opposite");   // wrong way or disabled
      write_entry(ADDR_INT_STAT, 32'h0003);
      read_entry(ADDR_INT_STAT, "irq_w1c");
      output_entry("irq_w1c_pins");
      pin_entry(16'h0000);
      read_entry(ADDR_INT_STAT, "irq_fall");
      write_entry(ADDR_INT_STAT, 32'h00FC);
      read_entry(ADDR_INT_STAT, "irq_clear");
      output_entry("irq_low");

      limit = 10 * op_q.size() + RESET_CYCLES + 100;

      repeat (RESET_CYCLES) @(posedge pclk);
      @(negedge pclk);
      reset = 1'b0;

      foreach (op_q[i])
      begin
         case (op_q[i])
            OP_WR: apb_write(addr_q[i], data_q[i]);
            OP_RD:
            begin
               apb_read(addr_q[i], rd);
               check_val(name_q[i], exp_q[i], rd);
            end
            OP_PIN:
            begin
               @(negedge pclk);
               gpio_pin_in = data_q[i][15:0];
               repeat (4) @(negedge pclk);   // sync plus status edge
            end
            OP_TRI:
            begin
               @(negedge pclk);
               tri_state_enable = data_q[i][15:0];
            end
            default:
            begin
               @(negedge pclk);
               check_val({name_q[i], "_out"}, data_q[i], {16'h0, gpio_pin_out});
               check_val({name_q[i], "_oe_n"}, {16'h0, exp_q[i][15:0]},
                         {16'h0, n_gpio_pin_oe});
               check_val({name_q[i], "_int"}, {31'h0, exp_q[i][16]}, {31'h0, gpio_int});
            end
         endcase
      end

      $display("STATUS: PASS");
      $finish;
   end

endmodule : tb_gpio_apb

// ==== filelist.f ====
rtl/gpio_pkg.sv
rtl/gpio_cfg_if.sv
rtl/gpio_apb_regs.sv
rtl/gpio_pin_ctrl.sv
rtl/gpio_apb_top.sv
test/tb_gpio_apb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the gpio testbench with Verilator, pass or fail from sim.log
set -e

cd "$(dirname "$0")"

verilator --binary -f filelist.f --top-module tb_gpio_apb -o tb_gpio_apb

status=0
./obj_dir/tb_gpio_apb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
   echo "simulation failed"
   exit 1
fi

if [ "$status" -ne 0 ] || ! grep -q "STATUS: PASS" sim.log; then
   echo "simulation ended without a pass result"
   exit 1
fi

exit 0
